// ==== hdl/memtest_mem_pkg.sv ====
/*
 * Memory-side definitions for the read-bandwidth tester
 *   - line address, region, stride and credit widths
 *   - read request and response structs
 *   - event counters and the read statistics bundle
 */
`default_nettype none

package memtest_mem_pkg;

    // ==============================
    // Widths
    // ==============================

    localparam int LINE_ADDR_BITS = 32;

    // Largest span an offset may cover inside the buffer
    localparam int REGION_BITS = 24;

    localparam int STRIDE_BITS = 16;

    // Enough for 2047 outstanding reads
    localparam int CREDIT_BITS = 11;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [STRIDE_BITS-1:0] stride_t;
    typedef logic [CREDIT_BITS-1:0] credit_t;

    // One event per cycle at most, so 32 bits hold a full run
    typedef logic [31:0] counter_t;

    // Per-cycle sum of in-flight reads needs the wider word
    typedef logic [63:0] total_t;

    // ==============================
    // Memory-side ports
    // ==============================

    // One line per request
    typedef struct packed
    {
        logic       valid;
        line_addr_t addr;
    } mem_rd_req_t;

    // Each response retires one request
    typedef struct packed
    {
        logic valid;
    } mem_rd_rsp_t;

    // Little's Law inputs, latency = inflight_total / rsp_cnt
    typedef struct packed
    {
        counter_t rsp_cnt;
        credit_t  inflight_max;
        total_t   inflight_total;
    } rd_stats_t;

endpackage

`default_nettype wire

// ==== hdl/memtest_csr_pkg.sv ====
/*
 * Host-side definitions for the read-bandwidth tester
 *   - CSR word map and tester ID
 *   - Wishbone classic request and response structs
 *   - run configuration struct and run state encoding
 */
`default_nettype none

package memtest_csr_pkg;

    localparam int CSR_DATA_BITS = 32;
    localparam int CSR_ADDR_BITS = 4;

    // ==============================
    // CSR word map
    // ==============================

    // Writing the budget starts a run
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CYCLES          = 4'd0;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_BASE            = 4'd1;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MASK            = 4'd2;
    // Stride in 15:0, read enable in 16
    localparam logic [CSR_ADDR_BITS-1:0] CSR_STRIDE          = 4'd3;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CREDITS         = 4'd4;
    // State in 1:0, raw almost-full in 2
    localparam logic [CSR_ADDR_BITS-1:0] CSR_STATUS          = 4'd5;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_RSP_CNT         = 4'd6;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_INFLIGHT_MAX    = 4'd7;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_INFLIGHT_TOT_LO = 4'd8;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_INFLIGHT_TOT_HI = 4'd9;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_CYCLES_EXEC     = 4'd10;
    localparam logic [CSR_ADDR_BITS-1:0] CSR_ID              = 4'd11;

    localparam logic [CSR_DATA_BITS-1:0] TESTER_ID = 32'h6da5_0a7d;

    // ==============================
    // Wishbone classic
    // ==============================

    typedef struct packed
    {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [CSR_ADDR_BITS-1:0] adr;
        logic [CSR_DATA_BITS-1:0] dat_w;
    } wb_req_t;

    typedef struct packed
    {
        logic                     ack;
        logic [CSR_DATA_BITS-1:0] dat_r;
    } wb_rsp_t;

    // Run setup, held by the CSR block
    typedef struct packed
    {
        memtest_mem_pkg::line_addr_t base;
        memtest_mem_pkg::line_addr_t mask;
        memtest_mem_pkg::stride_t    stride;
        logic                        rd_enable;
        memtest_mem_pkg::credit_t    credits;
    } run_cfg_t;

    typedef enum logic [1:0]
    {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2
    } run_state_t;

endpackage

`default_nettype wire

// ==== hdl/memtest_csr_block.sv ====
/*
 * CSR slave of the read-bandwidth tester
 *   - Wishbone classic decode with a registered single-cycle ack
 *   - config registers and the start pulse
 *   - read-only result map and tester ID
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_csr_block
(
    input  logic                        clk,
    input  logic                        reset,
    input  memtest_csr_pkg::wb_req_t    wb_req,
    output memtest_csr_pkg::wb_rsp_t    wb_rsp,
    output memtest_csr_pkg::run_cfg_t   cfg,
    output logic                        start,
    output memtest_mem_pkg::counter_t   cycle_budget,
    input  memtest_csr_pkg::run_state_t state,
    input  memtest_mem_pkg::counter_t   cycles_exec,
    input  memtest_mem_pkg::rd_stats_t  stats,
    input  logic                        mem_almost_full
);
    import memtest_csr_pkg::*;
    import memtest_mem_pkg::*;

    logic                     req_seen;
    logic                     wr_en;
    logic [CSR_DATA_BITS-1:0] rd_data;

    // New access, first cycle of cyc and stb without an ack out
    assign req_seen = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_en = req_seen && wb_req.we;

    // ==============================
    // Read mux
    // ==============================

    always_comb
    begin
        rd_data = '0;

        case (wb_req.adr)
            CSR_CYCLES:          rd_data = cycle_budget;
            CSR_BASE:            rd_data = cfg.base;
            CSR_MASK:            rd_data = cfg.mask;
            CSR_STRIDE:          rd_data = {15'b0, cfg.rd_enable, cfg.stride};
            CSR_CREDITS:         rd_data = CSR_DATA_BITS'(cfg.credits);
            CSR_STATUS:          rd_data = {29'b0, mem_almost_full, state};
            CSR_RSP_CNT:         rd_data = stats.rsp_cnt;
            CSR_INFLIGHT_MAX:    rd_data = CSR_DATA_BITS'(stats.inflight_max);
            CSR_INFLIGHT_TOT_LO: rd_data = stats.inflight_total[31:0];
            CSR_INFLIGHT_TOT_HI: rd_data = stats.inflight_total[63:32];
            CSR_CYCLES_EXEC:     rd_data = cycles_exec;
            CSR_ID:              rd_data = TESTER_ID;
            default:             rd_data = '0;
        endcase
    end

    // Ack one cycle after the request, data captured alongside
    always_ff @(posedge clk)
    begin
        wb_rsp.ack <= req_seen;

        if (req_seen)
        begin
            wb_rsp.dat_r <= rd_data;
        end

        if (reset)
        begin
            wb_rsp.ack <= 1'b0;
        end
    end

    // ==============================
    // Config writes
    // ==============================

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            case (wb_req.adr)
                CSR_CYCLES:  cycle_budget <= counter_t'(wb_req.dat_w);
                CSR_BASE:    cfg.base <= line_addr_t'(wb_req.dat_w);
                CSR_MASK:    cfg.mask <= line_addr_t'(wb_req.dat_w);
                CSR_STRIDE:
                begin
                    cfg.stride <= stride_t'(wb_req.dat_w);
                    cfg.rd_enable <= wb_req.dat_w[16];
                end
                CSR_CREDITS: cfg.credits <= credit_t'(wb_req.dat_w);
                default:     ;
            endcase
        end

        // Budget writes during a run only update the budget
        start <= wr_en && (wb_req.adr == CSR_CYCLES) && (state == IDLE);

        if (reset)
        begin
            cfg <= '0;
            // No credit limit until the host sets one
            cfg.credits <= '1;
            cycle_budget <= '0;
            start <= 1'b0;
        end
    end

    // Classic cycle, ack is a single pulse
    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack);

    // Every ack answers a strobe seen the cycle before
    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb));

endmodule

`default_nettype wire

// ==== hdl/memtest_run_ctrl.sv ====
/*
 * Run control of the read-bandwidth tester
 *   - IDLE, RUN and DRAIN state machine
 *   - cycle budget countdown and executed-cycle counter
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_run_ctrl
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  memtest_mem_pkg::counter_t   cycle_budget,
    input  logic                        rd_enable,
    input  logic                        drain_done,
    output memtest_csr_pkg::run_state_t state,
    output logic                        rd_active,
    output memtest_mem_pkg::counter_t   cycles_exec
);
    import memtest_csr_pkg::*;
    import memtest_mem_pkg::*;

    counter_t cycles_rem;
    logic     rd_enable_q;

    always_ff @(posedge clk)
    begin
        case (state)
            IDLE:
            begin
                // Budget and read enable frozen for the whole run
                if (start)
                begin
                    state <= RUN;
                    cycles_rem <= cycle_budget;
                    rd_enable_q <= rd_enable;
                    cycles_exec <= '0;
                end
            end

            RUN:
            begin
                if (cycles_rem == '0)
                begin
                    state <= DRAIN;
                end
                else
                begin
                    cycles_rem <= cycles_rem - counter_t'(1);
                end

                cycles_exec <= cycles_exec + counter_t'(1);
            end

            DRAIN:
            begin
                // Wait for the last response
                if (drain_done)
                begin
                    state <= IDLE;
                end

                cycles_exec <= cycles_exec + counter_t'(1);
            end

            default: state <= IDLE;
        endcase

        if (reset)
        begin
            state <= IDLE;
            cycles_rem <= '0;
            rd_enable_q <= 1'b0;
            cycles_exec <= '0;
        end
    end

    // Reads stop issuing as soon as the budget runs out
    assign rd_active = (state == RUN) && rd_enable_q;

    // DRAIN only follows an expired budget in RUN
    a_drain_from_run: assert property (@(posedge clk) disable iff (reset)
        (state == DRAIN) |-> ($past(state) == RUN || $past(state) == DRAIN));

endmodule

`default_nettype wire

// ==== hdl/memtest_rd_addr_gen.sv ====
/*
 * Read address generator of the read-bandwidth tester
 *   - registered almost-full and the issue decision
 *   - strided offset with wrap to a rotating base
 *   - memory read request register
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_rd_addr_gen
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  memtest_csr_pkg::run_cfg_t    cfg,
    input  logic                         rd_active,
    input  logic                         credit_ok,
    input  logic                         mem_almost_full,
    output memtest_mem_pkg::mem_rd_req_t rd_req
);
    import memtest_mem_pkg::*;

    logic       almost_full_q;
    logic       do_read;
    line_addr_t region_mask;
    line_addr_t offset;
    line_addr_t offset_next;
    stride_t    base_next;
    stride_t    base_max;

    // Held high through reset so nothing issues early
    always_ff @(posedge clk)
    begin
        almost_full_q <= mem_almost_full;

        if (reset)
        begin
            almost_full_q <= 1'b1;
        end
    end

    assign do_read = rd_active && !almost_full_q && credit_ok;

    // Offsets never leave the supported region
    assign region_mask = cfg.mask & line_addr_t'({REGION_BITS{1'b1}});

    // Last starting point before the pattern repeats
    assign base_max = (cfg.stride == '0) ? '0 :
                      (cfg.stride - stride_t'(1)) & stride_t'(region_mask);

    // ==============================
    // Offset walk
    // ==============================

    always_ff @(posedge clk)
    begin
        if (do_read)
        begin
            if (|(offset_next & ~region_mask))
            begin
                // Overflow: restart at the rotating base so each
                // stride covers the same lines on every pass
                offset <= line_addr_t'(base_next);
                offset_next <= line_addr_t'(base_next) + line_addr_t'(cfg.stride);

                if (base_next < base_max)
                begin
                    base_next <= base_next + stride_t'(1);
                end
                else
                begin
                    base_next <= '0;
                end
            end
            else
            begin
                offset <= offset_next;
                offset_next <= offset_next + line_addr_t'(cfg.stride);
            end
        end

        if (reset || start)
        begin
            offset <= '0;
            offset_next <= line_addr_t'(cfg.stride);
            base_next <= '0;
        end
    end

    // Request register, address follows the current offset
    always_ff @(posedge clk)
    begin
        rd_req.valid <= do_read;
        rd_req.addr <= cfg.base + offset;

        if (reset)
        begin
            rd_req.valid <= 1'b0;
        end
    end

    // Offset stays inside the masked buffer while reads run
    a_offset_in_mask: assert property (@(posedge clk) disable iff (reset)
        rd_active |-> ~|(offset & ~region_mask));

endmodule

`default_nettype wire

// ==== hdl/memtest_rd_tracker.sv ====
/*
 * Read tracker of the read-bandwidth tester
 *   - in-flight count with current, maximum and summed values
 *   - response counter
 *   - credit gate and drain detection
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_rd_tracker
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  memtest_mem_pkg::credit_t     credits,
    input  memtest_mem_pkg::mem_rd_req_t rd_req,
    input  memtest_mem_pkg::mem_rd_rsp_t rd_rsp,
    output logic                         credit_ok,
    output logic                         drain_done,
    output memtest_mem_pkg::rd_stats_t   stats
);
    import memtest_mem_pkg::*;

    logic                 rsp_q;
    credit_t              inflight;
    credit_t              inflight_next;
    logic [CREDIT_BITS:0] claim;

    // Issued request up, registered response down
    always_comb
    begin
        inflight_next = inflight;

        if (rd_req.valid && !rsp_q)
        begin
            inflight_next = inflight + credit_t'(1);
        end
        else if (!rd_req.valid && rsp_q)
        begin
            inflight_next = inflight - credit_t'(1);
        end
    end

    // A grant may still be in the request register path,
    // so a live credit_ok counts as one more read
    assign claim = {1'b0, inflight_next} + (CREDIT_BITS + 1)'(credit_ok);

    always_ff @(posedge clk)
    begin
        rsp_q <= rd_rsp.valid;
        inflight <= inflight_next;
        credit_ok <= (claim < {1'b0, credits});

        if (rsp_q)
        begin
            stats.rsp_cnt <= stats.rsp_cnt + counter_t'(1);
        end

        // Maximum lags the count by a cycle
        if (inflight > stats.inflight_max)
        begin
            stats.inflight_max <= inflight;
        end

        stats.inflight_total <= stats.inflight_total + total_t'(inflight);

        if (reset || start)
        begin
            rsp_q <= 1'b0;
            inflight <= '0;
            stats <= '0;
        end

        if (reset)
        begin
            credit_ok <= 1'b0;
        end
    end

    // Nothing outstanding and nothing in the request register
    assign drain_done = (inflight == '0) && !rd_req.valid;

    // Memory never answers more reads than were issued
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        (rsp_q && !rd_req.valid) |-> (inflight != '0));

endmodule

`default_nettype wire

// ==== hdl/memtest_top.sv ====
/*
 * Top level of the read-bandwidth tester
 *   - CSR block on the Wishbone side
 *   - run control, address generator and tracker on the memory side
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_top
(
    input  logic                         clk,
    input  logic                         reset,
    input  memtest_csr_pkg::wb_req_t     wb_req,
    output memtest_csr_pkg::wb_rsp_t     wb_rsp,
    input  logic                         mem_almost_full,
    output memtest_mem_pkg::mem_rd_req_t rd_req,
    input  memtest_mem_pkg::mem_rd_rsp_t rd_rsp
);
    import memtest_csr_pkg::*;
    import memtest_mem_pkg::*;

    run_cfg_t   cfg;
    logic       start;
    counter_t   cycle_budget;
    run_state_t state;
    counter_t   cycles_exec;
    rd_stats_t  stats;
    logic       rd_active;
    logic       credit_ok;
    logic       drain_done;

    // Host access and results
    memtest_csr_block csr0
    (
        .clk             (clk),
        .reset           (reset),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .cfg             (cfg),
        .start           (start),
        .cycle_budget    (cycle_budget),
        .state           (state),
        .cycles_exec     (cycles_exec),
        .stats           (stats),
        .mem_almost_full (mem_almost_full)
    );

    memtest_run_ctrl run_ctrl0
    (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cycle_budget (cycle_budget),
        .rd_enable    (cfg.rd_enable),
        .drain_done   (drain_done),
        .state        (state),
        .rd_active    (rd_active),
        .cycles_exec  (cycles_exec)
    );

    // Request stream toward memory
    memtest_rd_addr_gen rd_addr_gen0
    (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .cfg             (cfg),
        .rd_active       (rd_active),
        .credit_ok       (credit_ok),
        .mem_almost_full (mem_almost_full),
        .rd_req          (rd_req)
    );

    memtest_rd_tracker rd_tracker0
    (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .credits    (cfg.credits),
        .rd_req     (rd_req),
        .rd_rsp     (rd_rsp),
        .credit_ok  (credit_ok),
        .drain_done (drain_done),
        .stats      (stats)
    );

endmodule

`default_nettype wire

// ==== dv/memtest_tb.sv ====
/*
 * Testbench of the read-bandwidth tester
 *   - clock, reset and Wishbone classic CSR tasks
 *   - memory model with random latency and almost-full
 *   - address, credit, back-pressure and statistics checks
 *   - watchdog and closing report
 */
`timescale 1ns/1ps
`default_nettype none

module memtest_tb;
    import memtest_csr_pkg::*;
    import memtest_mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int BUDGET_SUM = 300 + 300 + 200;
    // CSR traffic and drain time on top of the budgets
    localparam int MARGIN_CYCLES = 4000;

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        mem_almost_full;
    mem_rd_req_t rd_req;
    mem_rd_rsp_t rd_rsp;

    integer      seed;
    int          errors;
    int          runs;
    int          req_total;
    int          cyc_now;
    int          out_cnt;
    int          due_q[$];
    logic        start_pending;

    // Config copy held by the testbench
    logic [31:0] cfg_base;
    logic [31:0] cfg_mask;
    logic [31:0] cfg_stride;
    logic [31:0] cfg_credits;
    logic [31:0] cfg_budget;

    // Reference model of address walk, run state and statistics
    logic [31:0] m_off;
    logic [31:0] m_next;
    logic [31:0] m_rbase;
    logic [31:0] m_exp_addr;
    logic [31:0] m_rem;
    logic [31:0] m_exec;
    logic [31:0] m_req_cnt;
    logic [31:0] m_inflight;
    logic [31:0] m_max;
    logic [63:0] m_total;
    logic        m_rspq;
    run_state_t  m_state;

    memtest_top dut0
    (
        .clk             (clk),
        .reset           (reset),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .mem_almost_full (mem_almost_full),
        .rd_req          (rd_req),
        .rd_rsp          (rd_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ==============================
    // Model, sampled on the rising edge
    // ==============================

    function automatic logic [31:0] region_mask();
        return cfg_mask & 32'h00ff_ffff;
    endfunction

    always @(posedge clk)
    begin
        cyc_now = cyc_now + 1;

        if (reset)
        begin
            m_state = IDLE;
            m_inflight = '0;
            m_rspq = 1'b0;
            out_cnt = 0;
        end
        else if (start_pending)
        begin
            // Start edge clears offsets, base and statistics
            start_pending = 1'b0;
            m_off = '0;
            m_next = cfg_stride;
            m_rbase = '0;
            m_exp_addr = cfg_base;
            m_state = RUN;
            m_rem = cfg_budget;
            m_exec = '0;
            m_req_cnt = '0;
            m_inflight = '0;
            m_max = '0;
            m_total = '0;
            m_rspq = 1'b0;
        end
        else
        begin
            if (rd_req.valid)
            begin
                m_req_cnt = m_req_cnt + 1;
                req_total = req_total + 1;
                out_cnt = out_cnt + 1;
                due_q.push_back(cyc_now + 1 + ($random(seed) & 7));

                // Overflow past the mask restarts at the rotating base
                if ((m_next & ~region_mask()) != 0)
                begin
                    m_off = m_rbase;
                    m_next = m_rbase + cfg_stride;
                    if (m_rbase < (cfg_stride == 0 ? 0 : (cfg_stride - 1) & region_mask()))
                        m_rbase = m_rbase + 1;
                    else
                        m_rbase = '0;
                end
                else
                begin
                    m_off = m_next;
                    m_next = m_next + cfg_stride;
                end
                m_exp_addr = cfg_base + m_off;
            end

            if (rd_rsp.valid)
                out_cnt = out_cnt - 1;

            case (m_state)
                RUN:
                begin
                    if (m_rem == 0)
                        m_state = DRAIN;
                    else
                        m_rem = m_rem - 1;
                    m_exec = m_exec + 1;
                end
                DRAIN:
                begin
                    if (m_inflight == 0 && !rd_req.valid)
                        m_state = IDLE;
                    m_exec = m_exec + 1;
                end
                default: ;
            endcase

            // Responses reach the in-flight count one cycle late
            m_total = m_total + 64'(m_inflight);
            if (m_inflight > m_max)
                m_max = m_inflight;
            m_inflight = m_inflight + 32'(rd_req.valid) - 32'(m_rspq);
            m_rspq = rd_rsp.valid;
        end
    end

    // Memory side driven on the falling edge, responses in order
    always @(negedge clk)
    begin
        rd_rsp.valid <= 1'b0;
        if (!reset)
        begin
            mem_almost_full <= (($random(seed) & 3) == 0);
            if (due_q.size() > 0 && due_q[0] <= cyc_now)
            begin
                void'(due_q.pop_front());
                rd_rsp.valid <= 1'b1;
            end
        end
    end

    // ==============================
    // Protocol and stream checks
    // ==============================

    a_tb_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
        errors = errors + 1;
        $display("Error %0t ns: ack held high for two cycles", $time);
    end

    a_tb_addr: assert property (@(posedge clk) disable iff (reset)
        rd_req.valid |-> (rd_req.addr == m_exp_addr))
    else
    begin
        errors = errors + 1;
        $display("Error %0t ns: request address %h, expected %h",
                 $time, $sampled(rd_req.addr), $sampled(m_exp_addr));
    end

    a_tb_credits: assert property (@(posedge clk) disable iff (reset)
        out_cnt <= int'(cfg_credits))
    else
    begin
        errors = errors + 1;
        $display("Error %0t ns: %0d reads outstanding, credits %0d",
                 $time, $sampled(out_cnt), $sampled(cfg_credits));
    end

    // Registered almost-full gives a two-edge stop
    a_tb_almost_full: assert property (@(posedge clk) disable iff (reset)
        $past(mem_almost_full, 2) |-> !rd_req.valid)
    else
    begin
        errors = errors + 1;
        $display("Error %0t ns: request issued while almost-full was high", $time);
    end

    // ==============================
    // Wishbone tasks
    // ==============================

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = 1'b1;
        wb_req.adr = adr;
        wb_req.dat_w = data;
        do
            @(negedge clk);
        while (!wb_rsp.ack);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
        // Start pulse follows on the next rising edge
        if (adr == CSR_CYCLES)
            start_pending = 1'b1;
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = 1'b0;
        wb_req.adr = adr;
        do
            @(negedge clk);
        while (!wb_rsp.ack);
        data = wb_rsp.dat_r;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
    endtask

    task automatic check_csr(input string what, input logic [3:0] adr,
                             input logic [31:0] exp);
        logic [31:0] got;
        wb_read(adr, got);
        assert (got == exp)
        else
        begin
            errors = errors + 1;
            $display("Error %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_test(input logic [31:0] base, input logic [31:0] mask,
                            input logic [31:0] stride, input logic [31:0] credits,
                            input logic [31:0] budget);
        logic [31:0] status;
        cfg_base = base;
        cfg_mask = mask;
        cfg_stride = stride;
        cfg_credits = credits;
        cfg_budget = budget;
        wb_write(CSR_BASE, base);
        wb_write(CSR_MASK, mask);
        wb_write(CSR_STRIDE, stride | 32'h0001_0000);
        wb_write(CSR_CREDITS, credits);
        check_csr("base", CSR_BASE, base);
        check_csr("mask", CSR_MASK, mask);
        check_csr("stride", CSR_STRIDE, stride | 32'h0001_0000);
        check_csr("credits", CSR_CREDITS, credits);
        wb_write(CSR_CYCLES, budget);

        // State leaves IDLE a cycle after the start pulse
        repeat (4) @(negedge clk);
        do
            wb_read(CSR_STATUS, status);
        while (status[1:0] != IDLE);

        // Model drain ends on the same edge as the DUT's
        assert (m_state == IDLE)
        else
        begin
            errors = errors + 1;
            $display("Error %0t ns: model state %0d when the DUT went idle",
                     $time, m_state);
        end

        check_csr("budget", CSR_CYCLES, budget);
        check_csr("response count", CSR_RSP_CNT, m_req_cnt);
        check_csr("in-flight max", CSR_INFLIGHT_MAX, m_max);
        check_csr("in-flight total low", CSR_INFLIGHT_TOT_LO, m_total[31:0]);
        check_csr("in-flight total high", CSR_INFLIGHT_TOT_HI, m_total[63:32]);
        check_csr("executed cycles", CSR_CYCLES_EXEC, m_exec);
        if (m_req_cnt == 0)
        begin
            errors = errors + 1;
            $display("The run with stride %0d issued no reads", stride);
        end
        runs = runs + 1;
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        seed = 32'h2c75_8dde;
        errors = 0;
        runs = 0;
        req_total = 0;
        cyc_now = 0;
        out_cnt = 0;
        start_pending = 1'b0;
        // Credit register comes out of reset all ones
        cfg_credits = 32'((1 << CREDIT_BITS) - 1);
        m_exp_addr = '0;
        reset = 1'b1;
        wb_req = '0;
        mem_almost_full = 1'b0;
        rd_rsp = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_csr("tester ID", CSR_ID, TESTER_ID);
        check_csr("reset credits", CSR_CREDITS, cfg_credits);
        // Stride divides the 256-line span
        run_test(32'h0001_0000, 32'h0000_00ff, 32'd16, 32'd4, 32'd300);
        // Stride leaves a remainder, single credit
        run_test(32'h0040_0000, 32'h0000_00ff, 32'd24, 32'd1, 32'd300);
        run_test(32'h0000_2000, 32'h0000_03ff, 32'd7, 32'd4, 32'd200);

        $display("Summary: %0d errors, %0d runs, %0d requests", errors, runs, req_total);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog sized from the run budgets
    initial
    begin
        #((BUDGET_SUM + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/memtest_mem_pkg.sv
hdl/memtest_csr_pkg.sv
hdl/memtest_csr_block.sv
hdl/memtest_run_ctrl.sv
hdl/memtest_rd_addr_gen.sv
hdl/memtest_rd_tracker.sv
hdl/memtest_top.sv
dv/memtest_tb.sv

// ==== Makefile ====
# Verilator build and run for the read-bandwidth tester

VERILATOR ?= verilator
TOP       ?= memtest_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
